//--- verilog/wb_pkg.sv
// Shared write-back types, the XER address and the SPR fairness enum, used by scoped name
package wb_pkg;

    // 32-bit GPR result or XER value
    typedef logic [0:31] word_t;

    // GPR register address
    typedef logic [0:4] gpr_addr_t;

    // SPR register address
    typedef logic [0:9] spr_addr_t;

    // Condition field, bit 0 is less-than, then greater-than, equal, summary-overflow
    typedef logic [0:3] cr_field_t;

    // XER sits at SPR address 1
    localparam spr_addr_t XER_SPR_ADDR = 10'd1;

    // Who wins the next XER/SPR collision
    typedef enum logic {
        TURN_GPR,
        TURN_SPR
    } spr_turn_t;

endpackage

//--- verilog/gpr_rr_search.sv
// Round-robin pointer over the GPR producers and the two candidate searches fed to grant control
`timescale 1ns/100ps

module gpr_rr_search #(
    parameter int ARBITER_DEPTH = 8
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [0:ARBITER_DEPTH-1]                               gpr_valid,
    input  logic [0:ARBITER_DEPTH-1]                               gpr_xer_valid,
    input  logic                                                   gpr_grant,
    input  logic [0:((ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1)-1] gpr_grant_idx,
    output logic                                                   next_found,
    output logic [0:((ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1)-1] next_idx,
    output logic                                                   noxer_found,
    output logic [0:((ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1)-1] noxer_idx
);

    localparam int IDX_WIDTH = (ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1;

    logic [0:IDX_WIDTH-1] last_idx;
    logic [0:IDX_WIDTH-1] start_idx;

    // Last granted unit starts at the top so the first search begins at unit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            last_idx <= IDX_WIDTH'(ARBITER_DEPTH - 1);
        end else if (gpr_grant) begin
            last_idx <= gpr_grant_idx;
        end
    end

    // Search starts one past the last winner and wraps at the depth
    always_comb begin
        if (last_idx == IDX_WIDTH'(ARBITER_DEPTH - 1)) begin
            start_idx = '0;
        end else begin
            start_idx = last_idx + IDX_WIDTH'(1);
        end
    end

    // Both first-match searches walk the same circular order
    always_comb begin
        int cur;

        next_found  = 1'b0;
        next_idx    = start_idx;
        noxer_found = 1'b0;
        noxer_idx   = start_idx;
        for (int i = 0; i < ARBITER_DEPTH; i++) begin
            cur = int'(start_idx) + i;
            if (cur >= ARBITER_DEPTH) begin
                cur = cur - ARBITER_DEPTH;
            end
            if (gpr_valid[cur] && !next_found) begin
                next_found = 1'b1;
                next_idx   = IDX_WIDTH'(cur);
            end
            // A unit without XER side effect can share the cycle with an SPR write
            if (gpr_valid[cur] && !gpr_xer_valid[cur] && !noxer_found) begin
                noxer_found = 1'b1;
                noxer_idx   = IDX_WIDTH'(cur);
            end
        end
    end

    // A grant always names a unit that presents a result
    a_grant_names_valid_unit: assert property (
        @(posedge clk) disable iff (rst) gpr_grant |-> gpr_valid[gpr_grant_idx]
    );

endmodule

//--- verilog/wb_grant_control.sv
// Per-cycle GPR and SPR grant decision with the SPR fairness turn, driven by the search results
`timescale 1ns/100ps

module wb_grant_control #(
    parameter int ARBITER_DEPTH = 8
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   spr_valid,
    input  logic                                                   next_found,
    input  logic [0:((ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1)-1] next_idx,
    input  logic                                                   noxer_found,
    input  logic [0:((ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1)-1] noxer_idx,
    input  logic [0:ARBITER_DEPTH-1]                               gpr_xer_valid,
    output logic                                                   gpr_grant,
    output logic [0:((ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1)-1] gpr_grant_idx,
    output logic                                                   spr_grant
);

    wb_pkg::spr_turn_t turn;
    wb_pkg::spr_turn_t turn_next;

    always_comb begin
        gpr_grant     = 1'b0;
        gpr_grant_idx = next_idx;
        spr_grant     = 1'b0;
        turn_next     = turn;

        if (!spr_valid) begin
            // No competition for the SPR port
            gpr_grant     = next_found;
            gpr_grant_idx = next_idx;
        end else if (turn == wb_pkg::TURN_SPR) begin
            // SPR wins and an XER-free result may still ride along
            spr_grant     = 1'b1;
            gpr_grant     = noxer_found;
            gpr_grant_idx = noxer_idx;
            turn_next     = wb_pkg::TURN_GPR;
        end else begin
            if (noxer_found) begin
                gpr_grant     = 1'b1;
                gpr_grant_idx = noxer_idx;
                spr_grant     = 1'b1;
            end else if (next_found) begin
                // Only XER producers are left so the GPR result goes first
                gpr_grant     = 1'b1;
                gpr_grant_idx = next_idx;
            end else begin
                spr_grant = 1'b1;
            end
            turn_next = wb_pkg::TURN_SPR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            turn <= wb_pkg::TURN_GPR;
        end else begin
            turn <= turn_next;
        end
    end

    // A paired grant never hands the SPR port to two XER writers
    a_pair_without_xer: assert property (
        @(posedge clk) disable iff (rst)
        (gpr_grant && spr_grant) |-> !gpr_xer_valid[gpr_grant_idx]
    );

endmodule

//--- verilog/wb_result_mux.sv
// Ready decode, granted data selection, CR0 computation and the registered write-back outputs
`timescale 1ns/100ps

module wb_result_mux #(
    parameter int RS_ID_WIDTH   = 5,
    parameter int ARBITER_DEPTH = 8
) (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   gpr_grant,
    input  logic [0:((ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1)-1] gpr_grant_idx,
    input  logic                                                   spr_grant,

    // GPR producers
    input  logic [0:ARBITER_DEPTH-1]                               gpr_valid,
    input  logic [0:RS_ID_WIDTH-1]                                 gpr_rs_id [0:ARBITER_DEPTH-1],
    input  wb_pkg::gpr_addr_t                                      gpr_addr [0:ARBITER_DEPTH-1],
    input  wb_pkg::word_t                                          gpr_result [0:ARBITER_DEPTH-1],
    input  logic [0:ARBITER_DEPTH-1]                               gpr_xer_valid,
    input  wb_pkg::word_t                                          gpr_xer [0:ARBITER_DEPTH-1],
    input  logic [0:ARBITER_DEPTH-1]                               gpr_cr0_valid,
    input  logic [0:ARBITER_DEPTH-1]                               gpr_so,

    // SPR producer
    input  logic [0:RS_ID_WIDTH-1]                                 spr_rs_id,
    input  wb_pkg::spr_addr_t                                      spr_addr,
    input  wb_pkg::word_t                                          spr_value,

    output logic [0:ARBITER_DEPTH-1]                               gpr_ready,
    output logic                                                   spr_ready,
    output logic                                                   gpr_out_valid,
    output logic [0:RS_ID_WIDTH-1]                                 gpr_out_rs_id,
    output wb_pkg::gpr_addr_t                                      gpr_out_addr,
    output wb_pkg::word_t                                          gpr_out_result,
    output logic                                                   spr_out_valid,
    output logic [0:RS_ID_WIDTH-1]                                 spr_out_rs_id,
    output wb_pkg::spr_addr_t                                      spr_out_addr,
    output wb_pkg::word_t                                          spr_out_value,
    output logic                                                   cr0_valid_out,
    output logic [0:RS_ID_WIDTH-1]                                 cr0_rs_id,
    output wb_pkg::cr_field_t                                      cr0_out
);

    logic gpr_take;
    logic xer_take;
    logic cr0_take;

    // Sign of the result decides LT/GT/EQ, SO is copied through
    function automatic wb_pkg::cr_field_t cr0_field(input wb_pkg::word_t result, input logic so);
        if ($signed(result) < 0) begin
            return {3'b100, so};
        end else if ($signed(result) > 0) begin
            return {3'b010, so};
        end else begin
            return {3'b001, so};
        end
    endfunction

    always_comb begin
        gpr_ready = '0;
        if (gpr_grant) begin
            gpr_ready[gpr_grant_idx] = 1'b1;
        end
    end

    assign spr_ready = spr_grant;

    assign gpr_take = gpr_grant && gpr_valid[gpr_grant_idx];
    assign xer_take = gpr_take && gpr_xer_valid[gpr_grant_idx];
    assign cr0_take = gpr_take && gpr_cr0_valid[gpr_grant_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            gpr_out_valid  <= 1'b0;
            gpr_out_rs_id  <= '0;
            gpr_out_addr   <= '0;
            gpr_out_result <= '0;
            spr_out_valid  <= 1'b0;
            spr_out_rs_id  <= '0;
            spr_out_addr   <= '0;
            spr_out_value  <= '0;
            cr0_valid_out  <= 1'b0;
            cr0_rs_id      <= '0;
            cr0_out        <= '0;
        end else begin
            gpr_out_valid <= gpr_take;
            spr_out_valid <= spr_grant || xer_take;
            cr0_valid_out <= cr0_take;
            if (gpr_take) begin
                gpr_out_rs_id  <= gpr_rs_id[gpr_grant_idx];
                gpr_out_addr   <= gpr_addr[gpr_grant_idx];
                gpr_out_result <= gpr_result[gpr_grant_idx];
            end
            // SPR port carries either the SPR write or the unit's XER update
            if (spr_grant) begin
                spr_out_rs_id <= spr_rs_id;
                spr_out_addr  <= spr_addr;
                spr_out_value <= spr_value;
            end else if (xer_take) begin
                spr_out_rs_id <= gpr_rs_id[gpr_grant_idx];
                spr_out_addr  <= wb_pkg::XER_SPR_ADDR;
                spr_out_value <= gpr_xer[gpr_grant_idx];
            end
            if (cr0_take) begin
                cr0_rs_id <= gpr_rs_id[gpr_grant_idx];
                cr0_out   <= cr0_field(gpr_result[gpr_grant_idx], gpr_so[gpr_grant_idx]);
            end
        end
    end

    // Grant control must never let both sources claim the SPR port
    a_spr_single_source: assert property (
        @(posedge clk) disable iff (rst) !(spr_grant && xer_take)
    );

endmodule

//--- verilog/wb_arbiter_top.sv
// Write-back arbiter top level, sets the parameters and connects search, grant control and output mux
`timescale 1ns/100ps

module wb_arbiter_top #(
    parameter int RS_ID_WIDTH   = 5,
    parameter int ARBITER_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,

    // GPR producers
    input  logic [0:ARBITER_DEPTH-1]     gpr_valid,
    output logic [0:ARBITER_DEPTH-1]     gpr_ready,
    input  logic [0:RS_ID_WIDTH-1]       gpr_rs_id [0:ARBITER_DEPTH-1],
    input  wb_pkg::gpr_addr_t            gpr_addr [0:ARBITER_DEPTH-1],
    input  wb_pkg::word_t                gpr_result [0:ARBITER_DEPTH-1],
    input  logic [0:ARBITER_DEPTH-1]     gpr_xer_valid,
    input  wb_pkg::word_t                gpr_xer [0:ARBITER_DEPTH-1],
    input  logic [0:ARBITER_DEPTH-1]     gpr_cr0_valid,
    input  logic [0:ARBITER_DEPTH-1]     gpr_so,

    // SPR producer
    input  logic                         spr_valid,
    output logic                         spr_ready,
    input  logic [0:RS_ID_WIDTH-1]       spr_rs_id,
    input  wb_pkg::spr_addr_t            spr_addr,
    input  wb_pkg::word_t                spr_value,

    // Register file write ports
    output logic                         gpr_out_valid,
    output logic [0:RS_ID_WIDTH-1]       gpr_out_rs_id,
    output wb_pkg::gpr_addr_t            gpr_out_addr,
    output wb_pkg::word_t                gpr_out_result,
    output logic                         spr_out_valid,
    output logic [0:RS_ID_WIDTH-1]       spr_out_rs_id,
    output wb_pkg::spr_addr_t            spr_out_addr,
    output wb_pkg::word_t                spr_out_value,
    output logic                         cr0_valid_out,
    output logic [0:RS_ID_WIDTH-1]       cr0_rs_id,
    output wb_pkg::cr_field_t            cr0_out
);

    localparam int IDX_WIDTH = (ARBITER_DEPTH > 1) ? $clog2(ARBITER_DEPTH) : 1;

    logic                 next_found;
    logic [0:IDX_WIDTH-1] next_idx;
    logic                 noxer_found;
    logic [0:IDX_WIDTH-1] noxer_idx;
    logic                 gpr_grant;
    logic [0:IDX_WIDTH-1] gpr_grant_idx;
    logic                 spr_grant;

    gpr_rr_search #(
        .ARBITER_DEPTH (ARBITER_DEPTH)
    ) i_gpr_rr_search (
        .clk           (clk),
        .rst           (rst),
        .gpr_valid     (gpr_valid),
        .gpr_xer_valid (gpr_xer_valid),
        .gpr_grant     (gpr_grant),
        .gpr_grant_idx (gpr_grant_idx),
        .next_found    (next_found),
        .next_idx      (next_idx),
        .noxer_found   (noxer_found),
        .noxer_idx     (noxer_idx)
    );

    // gpr_xer_valid feeds only the pairing check in grant control
    wb_grant_control #(
        .ARBITER_DEPTH (ARBITER_DEPTH)
    ) i_wb_grant_control (
        .clk           (clk),
        .rst           (rst),
        .spr_valid     (spr_valid),
        .next_found    (next_found),
        .next_idx      (next_idx),
        .noxer_found   (noxer_found),
        .noxer_idx     (noxer_idx),
        .gpr_xer_valid (gpr_xer_valid),
        .gpr_grant     (gpr_grant),
        .gpr_grant_idx (gpr_grant_idx),
        .spr_grant     (spr_grant)
    );

    wb_result_mux #(
        .RS_ID_WIDTH   (RS_ID_WIDTH),
        .ARBITER_DEPTH (ARBITER_DEPTH)
    ) i_wb_result_mux (
        .clk            (clk),
        .rst            (rst),
        .gpr_grant      (gpr_grant),
        .gpr_grant_idx  (gpr_grant_idx),
        .spr_grant      (spr_grant),
        .gpr_valid      (gpr_valid),
        .gpr_rs_id      (gpr_rs_id),
        .gpr_addr       (gpr_addr),
        .gpr_result     (gpr_result),
        .gpr_xer_valid  (gpr_xer_valid),
        .gpr_xer        (gpr_xer),
        .gpr_cr0_valid  (gpr_cr0_valid),
        .gpr_so         (gpr_so),
        .spr_rs_id      (spr_rs_id),
        .spr_addr       (spr_addr),
        .spr_value      (spr_value),
        .gpr_ready      (gpr_ready),
        .spr_ready      (spr_ready),
        .gpr_out_valid  (gpr_out_valid),
        .gpr_out_rs_id  (gpr_out_rs_id),
        .gpr_out_addr   (gpr_out_addr),
        .gpr_out_result (gpr_out_result),
        .spr_out_valid  (spr_out_valid),
        .spr_out_rs_id  (spr_out_rs_id),
        .spr_out_addr   (spr_out_addr),
        .spr_out_value  (spr_out_value),
        .cr0_valid_out  (cr0_valid_out),
        .cr0_rs_id      (cr0_rs_id),
        .cr0_out        (cr0_out)
    );

endmodule

//--- test/tb_wb_arbiter.sv
// Directed testbench for the write-back arbiter, run through run.sh with the project file list
`timescale 1ns/100ps

module tb_wb_arbiter;

    localparam int RS_ID_WIDTH   = 5;
    localparam int ARBITER_DEPTH = 8;
    localparam int WAIT_LIMIT    = 20;
    // Reset, six CR0 cases, the round-robin pass, SPR alone, pairing and collision
    localparam int TEST_CYCLES   = 6 + 6 * 5 + (ARBITER_DEPTH + 3) + 5 + 5 + 8;
    localparam int CYCLE_LIMIT   = 6 * TEST_CYCLES;

    logic                         clk;
    logic                         rst;
    logic [0:ARBITER_DEPTH-1]     gpr_valid;
    logic [0:ARBITER_DEPTH-1]     gpr_ready;
    logic [0:RS_ID_WIDTH-1]       gpr_rs_id [0:ARBITER_DEPTH-1];
    wb_pkg::gpr_addr_t            gpr_addr [0:ARBITER_DEPTH-1];
    wb_pkg::word_t                gpr_result [0:ARBITER_DEPTH-1];
    logic [0:ARBITER_DEPTH-1]     gpr_xer_valid;
    wb_pkg::word_t                gpr_xer [0:ARBITER_DEPTH-1];
    logic [0:ARBITER_DEPTH-1]     gpr_cr0_valid;
    logic [0:ARBITER_DEPTH-1]     gpr_so;
    logic                         spr_valid;
    logic                         spr_ready;
    logic [0:RS_ID_WIDTH-1]       spr_rs_id;
    wb_pkg::spr_addr_t            spr_addr;
    wb_pkg::word_t                spr_value;
    logic                         gpr_out_valid;
    logic [0:RS_ID_WIDTH-1]       gpr_out_rs_id;
    wb_pkg::gpr_addr_t            gpr_out_addr;
    wb_pkg::word_t                gpr_out_result;
    logic                         spr_out_valid;
    logic [0:RS_ID_WIDTH-1]       spr_out_rs_id;
    wb_pkg::spr_addr_t            spr_out_addr;
    wb_pkg::word_t                spr_out_value;
    logic                         cr0_valid_out;
    logic [0:RS_ID_WIDTH-1]       cr0_rs_id;
    wb_pkg::cr_field_t            cr0_out;

    int          mismatches;
    int          failures;
    int          cycles;
    logic [31:0] lfsr_state;

    wb_arbiter_top #(
        .RS_ID_WIDTH   (RS_ID_WIDTH),
        .ARBITER_DEPTH (ARBITER_DEPTH)
    ) i_wb_arbiter_top (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end else begin
            return state >> 1;
        end
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        mismatches++;
        $display("MISMATCH %s %s: expected %h, actual %h", test, what, expected, actual);
    endtask

    task automatic report_failure(input string test, input string text);
        failures++;
        $display("%s: %s", test, text);
    endtask

    task automatic drive_gpr(input int unit, input logic xer_on, input logic cr0_on,
                             input logic so, input wb_pkg::word_t result);
        gpr_valid[unit]     <= 1'b1;
        gpr_rs_id[unit]     <= RS_ID_WIDTH'(take_bits(RS_ID_WIDTH));
        gpr_addr[unit]      <= 5'(take_bits(5));
        gpr_result[unit]    <= result;
        gpr_xer_valid[unit] <= xer_on;
        gpr_xer[unit]       <= take_bits(32);
        gpr_cr0_valid[unit] <= cr0_on;
        gpr_so[unit]        <= so;
    endtask

    task automatic release_gpr(input int unit);
        gpr_valid[unit]     <= 1'b0;
        gpr_xer_valid[unit] <= 1'b0;
        gpr_cr0_valid[unit] <= 1'b0;
    endtask

    // Address kept well away from XER
    task automatic drive_spr();
        spr_valid <= 1'b1;
        spr_rs_id <= RS_ID_WIDTH'(take_bits(RS_ID_WIDTH));
        spr_addr  <= 10'(take_bits(10) | 32'h100);
        spr_value <= take_bits(32);
    endtask

    // Called at a falling edge, returns at the falling edge where ready is seen
    task automatic wait_gpr_ready(input string test, input int unit);
        int n;
        n = 0;
        while (gpr_ready[unit] !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (gpr_ready[unit] !== 1'b1) begin
            report_failure(test, $sformatf("unit %0d never saw its ready", unit));
        end
    endtask

    task automatic wait_spr_ready(input string test);
        int n;
        n = 0;
        while (spr_ready !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (spr_ready !== 1'b1) begin
            report_failure(test, "SPR input never saw its ready");
        end
    endtask

    task automatic check_idle(input string test);
        if (gpr_ready !== '0 || spr_ready !== 1'b0 || gpr_out_valid !== 1'b0 ||
            spr_out_valid !== 1'b0 || cr0_valid_out !== 1'b0) begin
            report_failure(test, "a ready or valid output is high while idle");
        end
    endtask

    task automatic check_gpr_out(input string test, input int unit);
        if (gpr_out_valid !== 1'b1) begin
            report_failure(test, $sformatf("no GPR write one cycle after unit %0d", unit));
        end
        if (gpr_out_rs_id !== gpr_rs_id[unit]) begin
            report_mismatch(test, "gpr_out_rs_id", 32'(gpr_rs_id[unit]), 32'(gpr_out_rs_id));
        end
        if (gpr_out_addr !== gpr_addr[unit]) begin
            report_mismatch(test, "gpr_out_addr", 32'(gpr_addr[unit]), 32'(gpr_out_addr));
        end
        if (gpr_out_result !== gpr_result[unit]) begin
            report_mismatch(test, "gpr_out_result", gpr_result[unit], gpr_out_result);
        end
    endtask

    task automatic check_spr_out(input string test, input logic [0:RS_ID_WIDTH-1] rs_id,
                                 input wb_pkg::spr_addr_t addr, input wb_pkg::word_t value);
        if (spr_out_valid !== 1'b1) begin
            report_failure(test, "no SPR write one cycle after the transfer");
        end
        if (spr_out_rs_id !== rs_id) begin
            report_mismatch(test, "spr_out_rs_id", 32'(rs_id), 32'(spr_out_rs_id));
        end
        if (spr_out_addr !== addr) begin
            report_mismatch(test, "spr_out_addr", 32'(addr), 32'(spr_out_addr));
        end
        if (spr_out_value !== value) begin
            report_mismatch(test, "spr_out_value", value, spr_out_value);
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_idle("reset");
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle("reset");
        @(negedge clk);
        check_idle("reset");
    endtask

    // Last unit, so the pointer ends at the top for the round-robin pass
    task automatic test_single_gpr();
        int                unit;
        logic              so;
        logic [31:0]       bits;
        wb_pkg::word_t     value;
        wb_pkg::cr_field_t exp_cr;
        unit = ARBITER_DEPTH - 1;
        for (int c = 0; c < 6; c++) begin
            so   = c[0];
            bits = take_bits(31);
            if (c / 2 == 0) begin
                value  = {1'b1, bits[30:0]};
                exp_cr = {3'b100, so};
            end else if (c / 2 == 1) begin
                value  = {1'b0, bits[30:1], 1'b1};
                exp_cr = {3'b010, so};
            end else begin
                value  = '0;
                exp_cr = {3'b001, so};
            end
            @(posedge clk);
            drive_gpr(unit, 1'b0, 1'b1, so, value);
            @(negedge clk);
            wait_gpr_ready("single_gpr", unit);
            @(posedge clk);
            release_gpr(unit);
            @(negedge clk);
            check_gpr_out("single_gpr", unit);
            if (cr0_valid_out !== 1'b1) begin
                report_failure("single_gpr", "no CR0 update for a result with cr0_valid");
            end
            if (cr0_rs_id !== gpr_rs_id[unit]) begin
                report_mismatch("single_gpr", "cr0_rs_id", 32'(gpr_rs_id[unit]), 32'(cr0_rs_id));
            end
            if (cr0_out !== exp_cr) begin
                report_mismatch("single_gpr", "cr0_out", 32'(exp_cr), 32'(cr0_out));
            end
            if (spr_out_valid !== 1'b0) begin
                report_failure("single_gpr", "SPR write without an XER update");
            end
            @(negedge clk);
            if (gpr_out_valid !== 1'b0 || cr0_valid_out !== 1'b0) begin
                report_failure("single_gpr", "outputs stayed valid for more than one cycle");
            end
        end
    endtask

    task automatic test_round_robin();
        logic [0:ARBITER_DEPTH-1] exp_ready;
        @(posedge clk);
        for (int u = 0; u < ARBITER_DEPTH; u++) begin
            drive_gpr(u, 1'b0, 1'b0, 1'b0, take_bits(32));
        end
        for (int k = 0; k <= ARBITER_DEPTH; k++) begin
            @(negedge clk);
            if (k > 0) begin
                check_gpr_out("round_robin", k - 1);
            end
            if (k < ARBITER_DEPTH) begin
                exp_ready    = '0;
                exp_ready[k] = 1'b1;
                if (gpr_ready !== exp_ready) begin
                    report_mismatch("round_robin", "gpr_ready", 32'(exp_ready), 32'(gpr_ready));
                end
                @(posedge clk);
                release_gpr(k);
            end
        end
    endtask

    // Turn is TURN_GPR here, the lone SPR write wins and flips it to TURN_SPR
    task automatic test_spr_alone();
        @(posedge clk);
        drive_spr();
        @(negedge clk);
        wait_spr_ready("spr_alone");
        @(posedge clk);
        spr_valid <= 1'b0;
        @(negedge clk);
        check_spr_out("spr_alone", spr_rs_id, spr_addr, spr_value);
        if (gpr_out_valid !== 1'b0 || cr0_valid_out !== 1'b0) begin
            report_failure("spr_alone", "GPR or CR0 write without a GPR producer");
        end
    endtask

    task automatic test_pairing();
        @(posedge clk);
        drive_gpr(2, 1'b0, 1'b0, 1'b0, take_bits(32));
        drive_spr();
        @(negedge clk);
        wait_gpr_ready("pairing", 2);
        if (spr_ready !== 1'b1) begin
            report_failure("pairing", "SPR write not granted with the XER-free unit");
        end
        @(posedge clk);
        release_gpr(2);
        spr_valid <= 1'b0;
        @(negedge clk);
        check_gpr_out("pairing", 2);
        check_spr_out("pairing", spr_rs_id, spr_addr, spr_value);
    endtask

    // Pairing left the turn at TURN_GPR, so the XER producer goes first
    task automatic test_xer_collision();
        @(posedge clk);
        drive_gpr(5, 1'b1, 1'b0, 1'b0, take_bits(32));
        drive_spr();
        @(negedge clk);
        wait_gpr_ready("xer_collision", 5);
        if (spr_ready !== 1'b0) begin
            report_failure("xer_collision", "SPR write granted together with an XER update");
        end
        @(posedge clk);
        release_gpr(5);
        @(negedge clk);
        check_gpr_out("xer_collision", 5);
        check_spr_out("xer_collision", gpr_rs_id[5], wb_pkg::XER_SPR_ADDR, gpr_xer[5]);
        wait_spr_ready("xer_collision");
        @(posedge clk);
        spr_valid <= 1'b0;
        @(negedge clk);
        check_spr_out("xer_collision", spr_rs_id, spr_addr, spr_value);
        if (gpr_out_valid !== 1'b0) begin
            report_failure("xer_collision", "GPR write repeated after the XER update");
        end
    endtask

    initial begin
        mismatches    = 0;
        failures      = 0;
        cycles        = 0;
        lfsr_state    = 32'hd608;
        rst           = 1'b1;
        gpr_valid     = '0;
        gpr_xer_valid = '0;
        gpr_cr0_valid = '0;
        gpr_so        = '0;
        for (int u = 0; u < ARBITER_DEPTH; u++) begin
            gpr_rs_id[u]  = '0;
            gpr_addr[u]   = '0;
            gpr_result[u] = '0;
            gpr_xer[u]    = '0;
        end
        spr_valid = 1'b0;
        spr_rs_id = '0;
        spr_addr  = '0;
        spr_value = '0;

        test_reset();
        test_single_gpr();
        test_round_robin();
        test_spr_alone();
        test_pairing();
        test_xer_collision();

        $display("Mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- wb_arbiter.f
verilog/wb_pkg.sv
verilog/gpr_rr_search.sv
verilog/wb_grant_control.sv
verilog/wb_result_mux.sv
verilog/wb_arbiter_top.sv
test/tb_wb_arbiter.sv

//--- run.sh
#!/bin/sh
# Build the write-back arbiter testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
    -f wb_arbiter.f \
    --top-module tb_wb_arbiter \
    -Mdir obj_dir \
    -o tb_wb_arbiter
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_wb_arbiter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
